/* hw/rpPkg.sv */
`default_nettype none

package rpPkg;

   //////////////////////////////////////////////////////////////////////////
   // Register bus
   //////////////////////////////////////////////////////////////////////////

   // Register addresses seen by the controller
   // Holes at 3 and above 5 read as zero
   typedef enum logic [4:0]
   {
      REG_CS1 = 5'd0,
      REG_DS  = 5'd1,
      REG_ER1 = 5'd2,
      REG_AS  = 5'd4,
      REG_DA  = 5'd5
   } regAddrE;

   // Function codes from CS1 bits 5:1
   // GO is CS1 bit 0 and is not part of the code
   typedef enum logic [4:0]
   {
      FN_NOP    = 5'h00,
      FN_SEEK   = 5'h02,
      FN_DRVCLR = 5'h04,
      FN_PRESET = 5'h08,
      FN_PAKACK = 5'h09,
      FN_WRITE  = 5'h18,
      FN_READ   = 5'h1C
   } rpFuncE;

   // One request from the controller
   typedef struct packed
   {
      logic        write;
      regAddrE     addr;
      logic [15:0] data;
   } regReqT;

   // One read response
   typedef struct packed
   {
      logic [15:0] data;
   } regRspT;

   //////////////////////////////////////////////////////////////////////////
   // Pipeline payloads
   //////////////////////////////////////////////////////////////////////////

   // Decoded write, one cycle wide, from decode to the stage-2 blocks
   typedef struct packed
   {
      logic        go;        // CS1 write with GO set
      rpFuncE      func;      // NOP when the code was illegal
      logic        illegal;   // Code not in the function table
      logic        daWrite;   // DA register load
      logic [15:0] daData;
      logic        clrAta;    // AS write with bit 0
      logic        clrAll;    // Bus init
   } driveEventT;

   // Disk address, DA bits 12:8 and 4:0
   typedef struct packed
   {
      logic [4:0] track;
      logic [4:0] sector;
   } diskAddrT;

   // Error register 1 bits
   localparam int ER1_ILF = 0;
   localparam int ER1_RMR = 2;
   localparam int ER1_IAE = 10;
   localparam int ER1_WLE = 11;

   // Drive status bits, upper ten bits of DS
   localparam int DS_ATA = 15;
   localparam int DS_ERR = 14;
   localparam int DS_PIP = 13;
   localparam int DS_MOL = 12;
   localparam int DS_WRL = 11;
   localparam int DS_LST = 10;
   localparam int DS_PGM = 9;   // Always zero here
   localparam int DS_DPR = 8;
   localparam int DS_DRY = 7;
   localparam int DS_VV  = 6;

endpackage

`default_nettype wire

/* hw/rpCmdDecode.sv */
`default_nettype none
`timescale 1ns/1ns

module rpCmdDecode
#(
   parameter int CREDITS = 2
)
(
   input  wire                 clk,
   input  wire                 rst,
   input  wire                 reqValid,
   input  wire rpPkg::regReqT  req,
   output logic                creditReturn,
   output logic                rspValid,
   output rpPkg::regRspT       rsp,
   input  wire [15:0]          ds,
   input  wire [15:0]          er1,
   input  wire rpPkg::diskAddrT da,
   input  wire                 busInit,
   output rpPkg::driveEventT   driveEvent
);

   import rpPkg::*;

   localparam int CW = $clog2(CREDITS + 1);

   logic [15:0] rdData;
   rpFuncE      reqFunc;
   logic        funcLegal;
   driveEventT  nextEvent;
   logic [CW-1:0] creditsLeft;

   //////////////////////////////////////////////////////////////////////////
   // Read path
   //////////////////////////////////////////////////////////////////////////

   // Register values as they stand in the request cycle
   always_comb
   begin
      case (req.addr)
         REG_DS:  rdData = ds;
         REG_ER1: rdData = er1;
         REG_DA:  rdData = {3'b000, da.track, 3'b000, da.sector};
         default: rdData = '0;
      endcase
   end

   //////////////////////////////////////////////////////////////////////////
   // Write path
   //////////////////////////////////////////////////////////////////////////

   // Function field of a CS1 write
   always_comb
   begin
      reqFunc = rpFuncE'(req.data[5:1]);
      case (req.data[5:1])
         FN_NOP, FN_SEEK, FN_DRVCLR, FN_PRESET,
         FN_PAKACK, FN_WRITE, FN_READ: funcLegal = 1'b1;
         default:                      funcLegal = 1'b0;
      endcase
   end

   // Writes become one event; bus init rides along every cycle
   always_comb
   begin
      nextEvent = '0;
      nextEvent.clrAll = busInit;
      if (reqValid && req.write)
      begin
         case (req.addr)
            REG_CS1:
            begin
               // Without GO nothing is started
               if (req.data[0])
               begin
                  nextEvent.go      = 1'b1;
                  nextEvent.illegal = !funcLegal;
                  nextEvent.func    = funcLegal ? reqFunc : FN_NOP;
               end
            end
            REG_DA:
            begin
               nextEvent.daWrite = 1'b1;
               nextEvent.daData  = req.data;
            end
            REG_AS:
               nextEvent.clrAta = req.data[0];
            default:
               nextEvent.clrAta = 1'b0;
         endcase
      end
   end

   // Control flags and the event register
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         creditReturn <= 1'b0;
         rspValid     <= 1'b0;
         driveEvent   <= '0;
      end
      else
      begin
         // Every request is taken at once, so credit goes back next cycle
         creditReturn <= reqValid;
         rspValid     <= reqValid && !req.write;
         driveEvent   <= nextEvent;
      end
   end

   // Read data
   always_ff @(posedge clk)
   begin
      if (reqValid && !req.write)
         rsp.data <= rdData;
   end

   // Controller side credit count, mirrored for checking
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         creditsLeft <= CW'(CREDITS);
      else if (reqValid && !creditReturn)
         creditsLeft <= creditsLeft - 1'b1;
      else if (!reqValid && creditReturn)
         creditsLeft <= creditsLeft + 1'b1;
   end

   // Response only for a read one cycle earlier
   rspFollowsRead: assert property (@(posedge clk) disable iff (rst)
      rspValid |-> $past(reqValid && !req.write))
      else $error("rpCmdDecode: response without a read request");

   // No request beyond the granted credits
   creditsHeld: assert property (@(posedge clk) disable iff (rst)
      reqValid |-> creditsLeft != '0)
      else $error("rpCmdDecode: more than CREDITS requests outstanding");

endmodule

`default_nettype wire

/* hw/rpDiskAddr.sv */
`default_nettype none
`timescale 1ns/1ns

module rpDiskAddr
#(
   parameter int TRACKS  = 19,
   parameter int SECTORS = 20
)
(
   input  wire                    clk,
   input  wire                    rst,
   input  wire rpPkg::driveEventT driveEvent,
   input  wire                    dry,
   output rpPkg::diskAddrT        da,
   output logic                   addrBad,
   output logic                   setLst
);

   import rpPkg::*;

   localparam logic [4:0] LAST_TRACK  = 5'(TRACKS - 1);
   localparam logic [4:0] LAST_SECTOR = 5'(SECTORS - 1);

   logic isXfer;
   logic advance;

   // Address beyond the pack geometry
   assign addrBad = (int'(da.track) >= TRACKS) || (int'(da.sector) >= SECTORS);

   // Legal READ or WRITE
   assign isXfer = driveEvent.go && !driveEvent.illegal &&
                   (driveEvent.func == FN_READ || driveEvent.func == FN_WRITE);

   // One sector moves only when ready and in range
   assign advance = isXfer && dry && !addrBad;

   //////////////////////////////////////////////////////////////////////////
   // DA register
   //////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         da     <= '0;
         setLst <= 1'b0;
      end
      else
      begin
         setLst <= 1'b0;
         if (driveEvent.clrAll)
            da <= '0;
         else if (driveEvent.daWrite)
         begin
            da.track  <= driveEvent.daData[12:8];
            da.sector <= driveEvent.daData[4:0];
         end
         else if (advance)
         begin
            if (da.sector == LAST_SECTOR)
            begin
               da.sector <= '0;
               // End of pack wraps to 0/0
               if (da.track == LAST_TRACK)
               begin
                  da.track <= '0;
                  setLst   <= 1'b1;
               end
               else
                  da.track <= da.track + 1'b1;
            end
            else
               da.sector <= da.sector + 1'b1;
         end
      end
   end

   // Last sector only at the end of a transfer, landing on 0/0
   lstFromXfer: assert property (@(posedge clk) disable iff (rst)
      setLst |-> $past(isXfer) && da == '0)
      else $error("rpDiskAddr: setLst without a READ or WRITE");

endmodule

`default_nettype wire

/* hw/rpErrors.sv */
`default_nettype none
`timescale 1ns/1ns

module rpErrors
#(
   parameter int SEEK_CYCLES = 12
)
(
   input  wire                    clk,
   input  wire                    rst,
   input  wire rpPkg::driveEventT driveEvent,
   input  wire                    addrBad,
   input  wire                    writeProtect,
   output logic [15:0]            er1,
   output logic                   pip,
   output logic                   dry,
   output logic                   setAta
);

   import rpPkg::*;

   localparam int CW = $clog2(SEEK_CYCLES + 1);

   logic          isGo;
   logic          isDrvClr;
   logic          isSeek;
   logic          isWrite;
   logic          isXfer;
   logic [15:0]   newErr;
   logic          startSeek;
   logic [CW-1:0] seekCount;

   //////////////////////////////////////////////////////////////////////////
   // Function checks
   //////////////////////////////////////////////////////////////////////////

   always_comb
   begin
      isGo     = driveEvent.go;
      isDrvClr = isGo && !driveEvent.illegal && driveEvent.func == FN_DRVCLR;
      isSeek   = isGo && !driveEvent.illegal && driveEvent.func == FN_SEEK;
      isWrite  = isGo && !driveEvent.illegal && driveEvent.func == FN_WRITE;
      isXfer   = isWrite ||
                 (isGo && !driveEvent.illegal && driveEvent.func == FN_READ);

      newErr = '0;
      newErr[ER1_ILF] = isGo && driveEvent.illegal;
      // Drive clear is always taken, even while busy
      newErr[ER1_RMR] = isGo && !dry && !isDrvClr;
      newErr[ER1_IAE] = (isSeek || isXfer) && addrBad;
      newErr[ER1_WLE] = isWrite && writeProtect;

      // Seek only from idle and clean
      startSeek = isSeek && newErr == '0;
   end

   // Error register 1, sticky until drive clear or bus init
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         er1 <= '0;
      else if (driveEvent.clrAll || isDrvClr)
         er1 <= '0;
      else
         er1 <= er1 | newErr;
   end

   //////////////////////////////////////////////////////////////////////////
   // Seek timer
   //////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         seekCount <= '0;
      else if (driveEvent.clrAll || isDrvClr)
         seekCount <= '0;   // Abort
      else if (startSeek)
         seekCount <= CW'(SEEK_CYCLES);
      else if (seekCount != '0)
         seekCount <= seekCount - 1'b1;
   end

   // Positioning while counting
   assign pip = seekCount != '0;
   assign dry = !pip;

   // Last count, so ATA lands with DRY in DS
   assign setAta = seekCount == CW'(1);

   // Never both busy and ready
   pipDry: assert property (@(posedge clk) disable iff (rst)
      !(pip && dry))
      else $error("rpErrors: pip and dry both high");

endmodule

`default_nettype wire

/* hw/rpDriveStatus.sv */
`default_nettype none
`timescale 1ns/1ns

module rpDriveStatus
(
   input  wire                    clk,
   input  wire                    rst,
   input  wire rpPkg::driveEventT driveEvent,
   input  wire                    setLst,
   input  wire                    setAta,
   input  wire                    pip,
   input  wire                    dry,
   input  wire [15:0]             er1,
   input  wire                    cardDetect,
   input  wire                    writeProtect,
   input  wire                    drivePresent,
   output logic [15:0]            ds
);

   import rpPkg::*;

   logic lastCd;
   logic cdEdge;
   logic cdRise;
   logic err;
   logic goSeen;
   logic isDrvClr;
   logic isValidate;
   logic ata;
   logic lst;
   logic vv;

   //////////////////////////////////////////////////////////////////////////
   // Card detect edges
   //////////////////////////////////////////////////////////////////////////

   // Starts off-line, so a card present at reset gives an edge
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         lastCd <= 1'b0;
      else
         lastCd <= cardDetect;
   end

   assign cdEdge = cardDetect != lastCd;
   assign cdRise = cardDetect && !lastCd;

   // Composite error
   assign err = |er1;

   assign isDrvClr   = driveEvent.go && !driveEvent.illegal &&
                       driveEvent.func == FN_DRVCLR;
   assign isValidate = driveEvent.go && !driveEvent.illegal &&
                       (driveEvent.func == FN_PRESET || driveEvent.func == FN_PAKACK);

   // GO one cycle late, in step with the error it may have raised
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         goSeen <= 1'b0;
      else
         goSeen <= driveEvent.go;
   end

   //////////////////////////////////////////////////////////////////////////
   // Status flops
   //////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         ata <= 1'b0;
         lst <= 1'b0;
         vv  <= 1'b0;
      end
      else
      begin
         // Attention, clears win
         if (driveEvent.clrAll || driveEvent.clrAta || isDrvClr)
            ata <= 1'b0;
         else if (setAta || cdEdge || (goSeen && err))
            ata <= 1'b1;

         // Last sector, cleared by a new address
         if (driveEvent.clrAll || driveEvent.daWrite)
            lst <= 1'b0;
         else if (setLst)
            lst <= 1'b1;

         // Volume valid lost when a pack comes on-line
         if (cdRise)
            vv <= 1'b0;
         else if (isValidate)
            vv <= 1'b1;
      end
   end

   // DS assembly, PGM and the low six bits stay zero
   always_comb
   begin
      ds = '0;
      ds[DS_ATA] = ata;
      ds[DS_ERR] = err;
      ds[DS_PIP] = pip;
      ds[DS_MOL] = cardDetect;
      ds[DS_WRL] = writeProtect;
      ds[DS_LST] = lst;
      ds[DS_DPR] = drivePresent;
      ds[DS_DRY] = dry;
      ds[DS_VV]  = vv;
   end

endmodule

`default_nettype wire

/* hw/rpDrive.sv */
`default_nettype none
`timescale 1ns/1ns

module rpDrive
#(
   parameter int CREDITS     = 2,
   parameter int TRACKS      = 19,
   parameter int SECTORS     = 20,
   parameter int SEEK_CYCLES = 12
)
(
   input  wire                 clk,
   input  wire                 rst,
   // Request channel
   input  wire                 reqValid,
   input  wire rpPkg::regReqT  req,
   output logic                creditReturn,
   // Response channel
   output logic                rspValid,
   output rpPkg::regRspT       rsp,
   // Drive side
   input  wire                 busInit,
   input  wire                 cardDetect,
   input  wire                 writeProtect,
   input  wire                 drivePresent
);

   import rpPkg::*;

   driveEventT  driveEvent;
   diskAddrT    da;
   logic [15:0] ds;
   logic [15:0] er1;
   logic        addrBad;
   logic        setLst;
   logic        pip;
   logic        dry;
   logic        setAta;

   //////////////////////////////////////////////////////////////////////////
   // Stage 1, decode
   //////////////////////////////////////////////////////////////////////////

   rpCmdDecode #(.CREDITS(CREDITS)) decode
   (
      .clk(clk), .rst(rst), .reqValid(reqValid), .req(req),
      .creditReturn(creditReturn), .rspValid(rspValid), .rsp(rsp),
      .ds(ds), .er1(er1), .da(da), .busInit(busInit), .driveEvent(driveEvent)
   );

   // Stage 2, address and errors
   rpDiskAddr #(.TRACKS(TRACKS), .SECTORS(SECTORS)) diskAddr
   (
      .clk(clk), .rst(rst), .driveEvent(driveEvent), .dry(dry),
      .da(da), .addrBad(addrBad), .setLst(setLst)
   );

   rpErrors #(.SEEK_CYCLES(SEEK_CYCLES)) errors
   (
      .clk(clk), .rst(rst), .driveEvent(driveEvent), .addrBad(addrBad),
      .writeProtect(writeProtect), .er1(er1), .pip(pip), .dry(dry), .setAta(setAta)
   );

   // Stage 3, status
   rpDriveStatus status
   (
      .clk(clk), .rst(rst), .driveEvent(driveEvent), .setLst(setLst),
      .setAta(setAta), .pip(pip), .dry(dry), .er1(er1), .cardDetect(cardDetect),
      .writeProtect(writeProtect), .drivePresent(drivePresent), .ds(ds)
   );

endmodule

`default_nettype wire

/* dv/rpDriveChecker.sv */
`default_nettype none
`timescale 1ns/1ns

module rpDriveChecker
(
   input  wire                  clk,
   input  wire                  rst,
   input  wire                  reqValid,
   input  wire                  reqWrite,
   input  wire                  creditReturn,
   input  wire                  rspValid,
   input  wire rpPkg::regRspT   rsp,
   input  wire                  expPush,
   input  wire [15:0]           expData,
   input  wire [15:0]           expMask,
   input  wire rpPkg::regAddrE  expReg,
   input  wire                  expPoll,
   input  wire                  pollDone,
   input  wire                  pollOk,
   output int                   testCount,
   output int                   failCount,
   output int                   rspCount,
   output int                   pending,
   output logic                 lastHit
);

   import rpPkg::*;

   // One expected read, queued in request order
   typedef struct packed
   {
      logic [15:0] data;
      logic [15:0] mask;
      regAddrE     addr;
      logic        poll;
   } expectT;

   expectT expQ[$];
   expectT cur;
   int     reqCount;
   int     returnCount;
   int     readCount;

   function automatic string regName(regAddrE a);
      case (a)
         REG_DS:  return "DS";
         REG_ER1: return "ER1";
         REG_DA:  return "DA";
         default: return "unmapped";
      endcase
   endfunction

   // Requests still waiting for a credit or a response
   assign pending = (reqCount - returnCount) + (readCount - rspCount);

   //////////////////////////////////////////////////////////////////////////
   // Monitor, sampled on the rising edge
   //////////////////////////////////////////////////////////////////////////

   always @(posedge clk)
   begin
      if (rst)
      begin
         testCount   = 0;
         failCount   = 0;
         rspCount    = 0;
         reqCount    = 0;
         returnCount = 0;
         readCount   = 0;
         lastHit     = 1'b0;
         expQ.delete();
      end
      else
      begin
         // Credit for an older request only
         if (creditReturn)
         begin
            if (returnCount >= reqCount)
            begin
               $display("t=%0t: credit came back with no request outstanding", $time);
               failCount++;
            end
            returnCount++;
         end

         // Response matched against the oldest read
         if (rspValid)
         begin
            rspCount++;
            if (expQ.size() == 0)
            begin
               $display("t=%0t: read response arrived with no read outstanding", $time);
               failCount++;
            end
            else
            begin
               cur = expQ.pop_front();
               lastHit = ((rsp.data ^ cur.data) & cur.mask) == 16'h0000;
               // Poll reads are judged once the poll ends
               if (!cur.poll)
               begin
                  testCount++;
                  if (lastHit)
                     $display("ok     test %0d  %s = %h", testCount, regName(cur.addr), rsp.data);
                  else
                  begin
                     failCount++;
                     $display("FAILED t=%0t test %0d rsp.data (%s) got %h expected %h mask %h",
                              $time, testCount, regName(cur.addr), rsp.data, cur.data, cur.mask);
                  end
               end
            end
         end

         // New requests, after the older traffic above
         if (reqValid)
         begin
            reqCount++;
            if (!reqWrite)
               readCount++;
         end
         if (expPush)
            expQ.push_back(expectT'{expData, expMask, expReg, expPoll});

         if (pollDone)
         begin
            testCount++;
            if (pollOk)
               $display("ok     test %0d  DS poll reached %h under mask %h",
                        testCount, expData, expMask);
            else
            begin
               failCount++;
               $display("test %0d: DS never reached %h under mask %h before the poll limit",
                        testCount, expData, expMask);
            end
         end
      end
   end

endmodule

`default_nettype wire

/* dv/rpDriveTb.sv */
`default_nettype none
`timescale 1ns/1ns

module rpDriveTb;

   import rpPkg::*;

   localparam int          CREDITS    = 2;
   localparam logic [31:0] SEED       = 32'h9e4b_6144;
   localparam int          WAIT_LIMIT = 20;
   localparam int          POLL_LIMIT = 40;

   // DS bits as the controller sees them
   localparam logic [15:0] ATA   = 16'h8000;
   localparam logic [15:0] ERR   = 16'h4000;
   localparam logic [15:0] PIP   = 16'h2000;
   localparam logic [15:0] WRL   = 16'h0800;
   localparam logic [15:0] LST   = 16'h0400;
   localparam logic [15:0] DRY   = 16'h0080;
   localparam logic [15:0] VV    = 16'h0040;
   localparam logic [15:0] READY = 16'h1000 | 16'h0100 | DRY;   // MOL, DPR, DRY

   typedef enum logic [2:0] {OP_IDLE, OP_WR, OP_RD, OP_BURST, OP_POLL} opE;

   // One table row, inputs first, then the expected read
   typedef struct packed
   {
      opE          op;
      regAddrE     addr;
      logic [15:0] data;
      logic        cd;
      logic        wp;
      logic [15:0] want;
      logic [15:0] mask;
   } rowT;

   logic        clk;
   logic        rst;
   logic        reqValid;
   regReqT      req;
   logic        creditReturn;
   logic        rspValid;
   regRspT      rsp;
   logic        busInit;
   logic        cardDetect;
   logic        writeProtect;
   logic        drivePresent;
   logic        expPush;
   logic [15:0] expData;
   logic [15:0] expMask;
   regAddrE     expReg;
   logic        expPoll;
   logic        pollDone;
   logic        pollOk;
   int          testCount;
   int          failCount;
   int          rspCount;
   int          pending;
   logic        lastHit;

   rowT         rows[$];
   int          sent = 0;
   int          returned = 0;
   int          readsSent = 0;
   int          tbErrors = 0;
   int          gap;

   always #4 clk = ~clk;

   // Controller side credit returns
   always @(posedge clk)
   begin
      if (creditReturn)
         returned <= returned + 1;
   end

   rpDrive #(.CREDITS(CREDITS)) dut
   (
      .clk(clk), .rst(rst), .reqValid(reqValid), .req(req), .creditReturn(creditReturn),
      .rspValid(rspValid), .rsp(rsp), .busInit(busInit), .cardDetect(cardDetect),
      .writeProtect(writeProtect), .drivePresent(drivePresent)
   );

   rpDriveChecker chk
   (
      .clk(clk), .rst(rst), .reqValid(reqValid), .reqWrite(req.write),
      .creditReturn(creditReturn), .rspValid(rspValid), .rsp(rsp), .expPush(expPush),
      .expData(expData), .expMask(expMask), .expReg(expReg), .expPoll(expPoll),
      .pollDone(pollDone), .pollOk(pollOk), .testCount(testCount), .failCount(failCount),
      .rspCount(rspCount), .pending(pending), .lastHit(lastHit)
   );

   function automatic rowT mkRow(opE op, regAddrE addr, logic [15:0] data, logic cd,
                                 logic wp, logic [15:0] want, logic [15:0] mask = 16'hFFFF);
      mkRow = '{op, addr, data, cd, wp, want, mask};
   endfunction

   // CS1 word with GO, code in bits 5:1
   function automatic logic [15:0] goWord(logic [4:0] code);
      goWord = {10'b0, code, 1'b1};
   endfunction

   //////////////////////////////////////////////////////////////////////////
   // Bus tasks, all entered 1 ns after a rising edge
   //////////////////////////////////////////////////////////////////////////

   task automatic nextCycle;
      @(posedge clk);
      #1;
   endtask

   task automatic takeCredit;
      int waited;
      waited = 0;
      while (sent - returned >= CREDITS && waited < WAIT_LIMIT)
      begin
         nextCycle();
         waited++;
      end
      if (sent - returned >= CREDITS)
      begin
         $display("t=%0t: no request credit came back within %0d cycles", $time, WAIT_LIMIT);
         tbErrors++;
      end
   endtask

   task automatic sendRequest(rowT r, logic poll);
      takeCredit();
      reqValid  = 1'b1;
      req.write = (r.op == OP_WR);
      req.addr  = r.addr;
      req.data  = r.data;
      // Reads tell the checker what to expect
      if (r.op != OP_WR)
      begin
         expPush = 1'b1;
         expData = r.want;
         expMask = r.mask;
         expReg  = r.addr;
         expPoll = poll;
         readsSent++;
      end
      sent++;
      nextCycle();
      reqValid = 1'b0;
      expPush  = 1'b0;
   endtask

   task automatic awaitResponses;
      int waited;
      waited = 0;
      while (rspCount != readsSent && waited < WAIT_LIMIT)
      begin
         nextCycle();
         waited++;
      end
      if (rspCount != readsSent)
      begin
         $display("t=%0t: read response missing after %0d cycles", $time, WAIT_LIMIT);
         tbErrors++;
      end
   endtask

   // Re-read DS until the masked value shows up
   task automatic pollStatus(rowT r);
      int tries;
      tries = 0;
      do
      begin
         sendRequest(r, 1'b1);
         awaitResponses();
         tries++;
      end
      while (!lastHit && tries < POLL_LIMIT);
      pollOk   = lastHit;
      pollDone = 1'b1;
      nextCycle();
      pollDone = 1'b0;
   endtask

   task automatic runRow(rowT r);
      cardDetect   = r.cd;
      writeProtect = r.wp;
      case (r.op)
         OP_WR, OP_RD, OP_BURST: sendRequest(r, 1'b0);
         OP_POLL:                pollStatus(r);
         default:                ;
      endcase
      if (r.op == OP_RD)
         awaitResponses();
      else if (r.op == OP_WR || r.op == OP_IDLE)
         repeat (3) nextCycle();   // Status settles three cycles after a write
   endtask

   task automatic awaitIdle;
      int waited;
      waited = 0;
      while (pending != 0 && waited < WAIT_LIMIT)
      begin
         nextCycle();
         waited++;
      end
      if (pending != 0)
      begin
         $display("t=%0t: %0d requests left without credit return or response", $time, pending);
         tbErrors++;
      end
   endtask

   //////////////////////////////////////////////////////////////////////////
   // Stimulus table
   //////////////////////////////////////////////////////////////////////////

   task automatic buildTable;
      // Reset with card in, ATA clear, card cycled
      rows.push_back(mkRow(OP_RD, REG_DS, 16'h0, 1'b1, 1'b0, ATA | READY));
      rows.push_back(mkRow(OP_WR, REG_AS, 16'h0001, 1'b1, 1'b0, 16'h0));
      rows.push_back(mkRow(OP_RD, REG_DS, 16'h0, 1'b1, 1'b0, READY));
      rows.push_back(mkRow(OP_IDLE, REG_DS, 16'h0, 1'b0, 1'b0, 16'h0));
      rows.push_back(mkRow(OP_RD, REG_DS, 16'h0, 1'b0, 1'b0, ATA | 16'h0100 | DRY));
      rows.push_back(mkRow(OP_IDLE, REG_DS, 16'h0, 1'b1, 1'b0, 16'h0));
      rows.push_back(mkRow(OP_RD, REG_DS, 16'h0, 1'b1, 1'b0, ATA | READY));
      // Volume valid
      rows.push_back(mkRow(OP_WR, REG_AS, 16'h0001, 1'b1, 1'b0, 16'h0));
      rows.push_back(mkRow(OP_WR, REG_CS1, goWord(FN_PRESET), 1'b1, 1'b0, 16'h0));
      rows.push_back(mkRow(OP_RD, REG_DS, 16'h0, 1'b1, 1'b0, READY | VV));
      rows.push_back(mkRow(OP_IDLE, REG_DS, 16'h0, 1'b0, 1'b0, 16'h0));
      rows.push_back(mkRow(OP_RD, REG_DS, 16'h0, 1'b0, 1'b0, ATA | 16'h0100 | DRY | VV));
      rows.push_back(mkRow(OP_IDLE, REG_DS, 16'h0, 1'b1, 1'b0, 16'h0));
      rows.push_back(mkRow(OP_RD, REG_DS, 16'h0, 1'b1, 1'b0, ATA | READY));
      rows.push_back(mkRow(OP_WR, REG_AS, 16'h0001, 1'b1, 1'b0, 16'h0));
      // Illegal code 01, then drive clear
      rows.push_back(mkRow(OP_WR, REG_CS1, goWord(5'h01), 1'b1, 1'b0, 16'h0));
      rows.push_back(mkRow(OP_RD, REG_ER1, 16'h0, 1'b1, 1'b0, 16'h0001));
      rows.push_back(mkRow(OP_RD, REG_DS, 16'h0, 1'b1, 1'b0, ATA | ERR | READY));
      rows.push_back(mkRow(OP_WR, REG_CS1, goWord(FN_DRVCLR), 1'b1, 1'b0, 16'h0));
      rows.push_back(mkRow(OP_RD, REG_ER1, 16'h0, 1'b1, 1'b0, 16'h0000));
      rows.push_back(mkRow(OP_RD, REG_DS, 16'h0, 1'b1, 1'b0, READY));
      // Seek to 3/5, then to sector 20
      rows.push_back(mkRow(OP_WR, REG_DA, 16'h0305, 1'b1, 1'b0, 16'h0));
      rows.push_back(mkRow(OP_WR, REG_CS1, goWord(FN_SEEK), 1'b1, 1'b0, 16'h0));
      rows.push_back(mkRow(OP_RD, REG_DS, 16'h0, 1'b1, 1'b0, PIP | 16'h1000 | 16'h0100));
      rows.push_back(mkRow(OP_POLL, REG_DS, 16'h0, 1'b1, 1'b0, ATA | DRY, ATA | PIP | DRY));
      rows.push_back(mkRow(OP_WR, REG_AS, 16'h0001, 1'b1, 1'b0, 16'h0));
      rows.push_back(mkRow(OP_WR, REG_DA, 16'h0314, 1'b1, 1'b0, 16'h0));
      rows.push_back(mkRow(OP_WR, REG_CS1, goWord(FN_SEEK), 1'b1, 1'b0, 16'h0));
      rows.push_back(mkRow(OP_RD, REG_ER1, 16'h0, 1'b1, 1'b0, 16'h0400));
      rows.push_back(mkRow(OP_RD, REG_DS, 16'h0, 1'b1, 1'b0, ATA | ERR | READY));
      rows.push_back(mkRow(OP_WR, REG_CS1, goWord(FN_DRVCLR), 1'b1, 1'b0, 16'h0));
      // Write lock, end of pack, track step
      rows.push_back(mkRow(OP_WR, REG_DA, 16'h0000, 1'b1, 1'b0, 16'h0));
      rows.push_back(mkRow(OP_WR, REG_CS1, goWord(FN_WRITE), 1'b1, 1'b1, 16'h0));
      rows.push_back(mkRow(OP_RD, REG_ER1, 16'h0, 1'b1, 1'b1, 16'h0800));
      rows.push_back(mkRow(OP_RD, REG_DS, 16'h0, 1'b1, 1'b1, ATA | ERR | WRL | READY));
      rows.push_back(mkRow(OP_WR, REG_CS1, goWord(FN_DRVCLR), 1'b1, 1'b0, 16'h0));
      rows.push_back(mkRow(OP_WR, REG_DA, 16'h1213, 1'b1, 1'b0, 16'h0));
      rows.push_back(mkRow(OP_WR, REG_CS1, goWord(FN_READ), 1'b1, 1'b0, 16'h0));
      rows.push_back(mkRow(OP_RD, REG_DA, 16'h0, 1'b1, 1'b0, 16'h0000));
      rows.push_back(mkRow(OP_RD, REG_DS, 16'h0, 1'b1, 1'b0, LST | READY));
      rows.push_back(mkRow(OP_WR, REG_DA, 16'h0513, 1'b1, 1'b0, 16'h0));
      rows.push_back(mkRow(OP_RD, REG_DS, 16'h0, 1'b1, 1'b0, READY));
      rows.push_back(mkRow(OP_WR, REG_CS1, goWord(FN_READ), 1'b1, 1'b0, 16'h0));
      rows.push_back(mkRow(OP_RD, REG_DA, 16'h0, 1'b1, 1'b0, 16'h0600));
      // Back to back reads on both credits
      rows.push_back(mkRow(OP_BURST, REG_DS, 16'h0, 1'b1, 1'b0, READY));
      rows.push_back(mkRow(OP_BURST, REG_ER1, 16'h0, 1'b1, 1'b0, 16'h0000));
      rows.push_back(mkRow(OP_BURST, REG_DA, 16'h0, 1'b1, 1'b0, 16'h0600));
      rows.push_back(mkRow(OP_BURST, REG_DS, 16'h0, 1'b1, 1'b0, READY));
      rows.push_back(mkRow(OP_RD, REG_DA, 16'h0, 1'b1, 1'b0, 16'h0600));
   endtask

   //////////////////////////////////////////////////////////////////////////
   // Run loop
   //////////////////////////////////////////////////////////////////////////

   initial
   begin
      clk          = 1'b0;
      rst          = 1'b1;
      reqValid     = 1'b0;
      req          = '0;
      busInit      = 1'b0;
      cardDetect   = 1'b1;
      writeProtect = 1'b0;
      drivePresent = 1'b1;
      expPush      = 1'b0;
      expData      = '0;
      expMask      = '0;
      expReg       = REG_CS1;
      expPoll      = 1'b0;
      pollDone     = 1'b0;
      pollOk       = 1'b0;
      void'($urandom(SEED));
      buildTable();

      repeat (3) @(posedge clk);
      #1 rst = 1'b0;
      // Card edge from reset lands in ATA first
      repeat (3) nextCycle();

      foreach (rows[i])
      begin
         runRow(rows[i]);
         // Bursts go out with no gap
         if (rows[i].op != OP_BURST)
         begin
            gap = int'($urandom % 4);
            repeat (gap) nextCycle();
         end
      end
      awaitIdle();

      $display("tests %0d, failed checks %0d, harness errors %0d",
               testCount, failCount, tbErrors);
      if (failCount == 0 && tbErrors == 0)
         $display("sim passed");
      else
         $display("sim failed");
      $finish;
   end

endmodule

`default_nettype wire

/* sources.f */
hw/rpPkg.sv
hw/rpCmdDecode.sv
hw/rpDiskAddr.sv
hw/rpErrors.sv
hw/rpDriveStatus.sv
hw/rpDrive.sv
dv/rpDriveChecker.sv
dv/rpDriveTb.sv

/* run.sh */
#!/bin/sh
# Build and run the drive register testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing -Wno-fatal --top-module rpDriveTb -f sources.f \
   -o rpDriveSim > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }

./obj_dir/rpDriveSim > sim.log 2>&1 || echo "simulator returned a failing status"
cat sim.log

# Result comes from the log
grep -qx "sim passed" sim.log && echo "result: pass" || { echo "result: fail"; exit 1; }
